//--- list.f
+incdir+include
hw/ts_replace_pkg.sv
hw/replace_regs.sv
hw/replace_packet_ram.sv
hw/ts_pid_replacer.sv
hw/ts_replace_top.sv
tb/tb_ts_replace.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_ts_replace
FILELIST   := list.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := all tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/ts_replace_config.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides, a fatal stop leaves no pass line
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_ts_replace.sv
`timescale 1ns/1ns
`default_nettype none
`include "ts_replace_config.svh"

module tb_ts_replace;

	localparam int CLK_HALF = 5;
	localparam int N_PACKETS = 9;
	localparam int STREAM_CYCLES = N_PACKETS * (`TS_PACKET_BYTES + 24) + 200;
	localparam int REG_CYCLES = 2 * (2 * ts_replace_pkg::RAM_WORDS + 60);
	localparam int WATCHDOG_NS = 2 * (STREAM_CYCLES + REG_CYCLES + 50) * 2 * CLK_HALF;

	// expected output pulse
	typedef struct packed {
		ts_replace_pkg::ts_beat_t beat;
		logic                     matched;
	} exp_out_t;

	logic                      S_AXI_ACLK;
	logic                      S_AXI_ARESETN;
	logic                      wr_strobe;
	ts_replace_pkg::reg_wr_t   wr;
	logic                      rd_strobe;
	ts_replace_pkg::reg_addr_t rd_addr;
	logic                      rd_valid;
	ts_replace_pkg::reg_data_t rd_data;
	logic                      ts_in_valid;
	ts_replace_pkg::ts_beat_t  ts_in;
	logic                      ts_out_valid;
	ts_replace_pkg::ts_beat_t  ts_out;
	logic                      matched;

	// ########################################
	// reference model state
	// ########################################
	exp_out_t                   exp_q [$];
	exp_out_t                   head;
	ts_replace_pkg::reg_data_t  ram_img [ts_replace_pkg::RAM_WORDS];
	ts_replace_pkg::pid_entry_t pid_model [`TS_PID_SLOTS];
	logic                       match_en_m;
	logic                       bypass_m;
	int                         group_m;
	logic                       in_valid_q;

	ts_replace_top uut (.*);

	initial begin
		S_AXI_ACLK = 1'b0;
		forever #CLK_HALF S_AXI_ACLK = ~S_AXI_ACLK;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input ts_replace_pkg::reg_data_t got,
			input ts_replace_pkg::reg_data_t want);
		if (got !== want)
			stop_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, want));
	endtask

	task automatic check_beat(input string name, input ts_replace_pkg::ts_beat_t got,
			input ts_replace_pkg::ts_beat_t want);
		if (got !== want)
			stop_run($sformatf("[FAIL] %s: got data 0x%h sync 0x%h, expected data 0x%h sync 0x%h",
				name, got.data, got.sync, want.data, want.sync));
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want)
			stop_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, want));
	endtask

	// each output pulse pops the next model beat
	always @(negedge S_AXI_ACLK) begin
		if (S_AXI_ARESETN) begin
			if (ts_out_valid !== in_valid_q)
				stop_run("ts_out_valid did not follow ts_in_valid by exactly one cycle");
			else if (ts_out_valid) begin
				if (exp_q.size() == 0)
					stop_run("output pulse arrived with no beat expected");
				else begin
					head = exp_q.pop_front();
					check_beat("ts_out", ts_out, head.beat);
					check_flag("matched", matched, head.matched);
				end
			end
		end
		in_valid_q = ts_in_valid;
	end

	initial begin
		#(WATCHDOG_NS);
		stop_run("watchdog expired before the tests finished");
	end

	// ########################################
	// bus and stream drivers
	// ########################################
	task automatic write_reg(input ts_replace_pkg::reg_addr_t addr,
			input ts_replace_pkg::reg_data_t data);
		@(posedge S_AXI_ACLK);
		#1;
		wr_strobe = 1'b1;
		wr.addr = addr;
		wr.data = data;
		@(posedge S_AXI_ACLK);
		#1;
		wr_strobe = 1'b0;
	endtask

	task automatic expect_reg(input ts_replace_pkg::reg_addr_t addr,
			input ts_replace_pkg::reg_data_t want, input string name);
		@(posedge S_AXI_ACLK);
		#1;
		rd_strobe = 1'b1;
		rd_addr = addr;
		@(posedge S_AXI_ACLK);
		#1;
		rd_strobe = 1'b0;
		rd_addr = '0;
		@(negedge S_AXI_ACLK);
		if (rd_valid !== 1'b1)
			stop_run("rd_valid did not pulse one cycle after rd_strobe");
		check_word(name, rd_data, want);
	endtask

	task automatic set_ctrl(input logic me, input logic byp);
		ts_replace_pkg::reg_data_t w;
		w = '0;
		w[0] = me;
		w[1] = byp;
		write_reg(`TS_ADDR_CTRL, w);
		match_en_m = me;
		bypass_m = byp;
	endtask

	function automatic ts_replace_pkg::reg_data_t pid_image(input ts_replace_pkg::pid_entry_t e);
		ts_replace_pkg::reg_data_t w;
		w = '0;
		w[12:0] = e.pid;
		w[16] = e.enable;
		return w;
	endfunction

	task automatic set_pid(input int slot, input logic en, input logic [12:0] pid);
		pid_model[slot].enable = en;
		pid_model[slot].pid = pid;
		write_reg(ts_replace_pkg::reg_addr_t'(`TS_ADDR_PID_BASE + slot), pid_image(pid_model[slot]));
	endtask

	function automatic logic pid_hits(input logic [12:0] pid);
		logic any;
		any = 1'b0;
		for (int i = 0; i < `TS_PID_SLOTS; i++)
			if (pid_model[i].enable && pid_model[i].pid == pid)
				any = 1'b1;
		return any && match_en_m && !bypass_m;
	endfunction

	task automatic send_beat(input ts_replace_pkg::ts_beat_t b, input exp_out_t e);
		@(posedge S_AXI_ACLK);
		#1;
		ts_in_valid = 1'b1;
		ts_in = b;
		exp_q.push_back(e);
	endtask

	task automatic idle(input int n);
		@(posedge S_AXI_ACLK);
		#1;
		ts_in_valid = 1'b0;
		repeat (n - 1) @(posedge S_AXI_ACLK);
	endtask

	// gap 0 leaves the strobe high for a packet that follows directly
	task automatic send_packet(input logic [12:0] pid, input int gap, input logic holes);
		logic [7:0]                pkt [`TS_PACKET_BYTES];
		ts_replace_pkg::ts_beat_t  b;
		exp_out_t                  e;
		ts_replace_pkg::ram_addr_t widx;
		ts_replace_pkg::reg_data_t w;
		logic                      replace;
		int                        grp;
		pkt[0] = `TS_SYNC_BYTE;
		pkt[1] = {3'($urandom), pid[12:8]};
		pkt[2] = pid[7:0];
		for (int k = 3; k < `TS_PACKET_BYTES; k++)
			pkt[k] = 8'($urandom);
		replace = pid_hits(pid);
		grp = group_m;
		if (replace)
			group_m = (group_m + 1) % `TS_REPLACE_GROUPS;
		for (int k = 0; k < `TS_PACKET_BYTES; k++) begin
			b.data = pkt[k];
			b.sync = (k == 0);
			e.beat.sync = b.sync;
			e.matched = replace;
			if (replace) begin
				widx = ts_replace_pkg::ram_addr_t'(grp * `TS_GROUP_WORDS + k / `TS_WORD_BYTES);
				w = ram_img[widx];
				e.beat.data = w[8 * (k % `TS_WORD_BYTES) +: 8]; // lane 0 is bits 7:0
			end else begin
				e.beat.data = pkt[k];
			end
			send_beat(b, e);
			if (holes && (k % 41 == 7))
				idle(1 + k % 3);
		end
		if (gap > 0)
			idle(gap);
	endtask

	// pushes the tail of the last packet out of the delay line
	task automatic flush();
		exp_out_t e;
		e = '0;
		repeat (3) send_beat('0, e);
		idle(4);
	endtask

	// ########################################
	// directed tests
	// ########################################
	task automatic test_reset_state();
		expect_reg(`TS_ADDR_CTRL, '0, "ctrl");
		for (int i = 0; i < `TS_PID_SLOTS; i++)
			expect_reg(ts_replace_pkg::reg_addr_t'(`TS_ADDR_PID_BASE + i), '0, "pid_slot");
		repeat (10) @(posedge S_AXI_ACLK); // monitor flags any output pulse
	endtask

	task automatic test_registers();
		ts_replace_pkg::reg_data_t w;
		write_reg(`TS_ADDR_PID_BASE, '1);
		pid_model[0] = '{enable: 1'b1, pid: 13'h1fff};
		expect_reg(`TS_ADDR_PID_BASE, 32'h0001_1fff, "pid_slot0");
		set_pid(0, 1'b1, 13'h0100);
		set_pid(1, 1'b0, 13'h0200);
		set_pid(2, 1'b1, 13'h1a5c);
		set_pid(3, 1'b0, 13'h0000);
		for (int i = 0; i < `TS_PID_SLOTS; i++)
			expect_reg(ts_replace_pkg::reg_addr_t'(`TS_ADDR_PID_BASE + i),
				pid_image(pid_model[i]), "pid_slot");
		set_ctrl(1'b1, 1'b1);
		expect_reg(`TS_ADDR_CTRL, 32'h3, "ctrl");
		set_ctrl(1'b0, 1'b0);
		write_reg(12'h001, '1); // unmapped address is ignored
		expect_reg(`TS_ADDR_CTRL, '0, "ctrl");
		for (int i = 0; i < ts_replace_pkg::RAM_WORDS; i++) begin
			w = $urandom;
			ram_img[i] = w;
			write_reg(ts_replace_pkg::reg_addr_t'(`TS_ADDR_DATA_BASE + i), w);
		end
		for (int i = 0; i < ts_replace_pkg::RAM_WORDS; i++)
			expect_reg(ts_replace_pkg::reg_addr_t'(`TS_ADDR_DATA_BASE + i), ram_img[i], "data_word");
		expect_reg(12'h001, '0, "unmapped");
		expect_reg(ts_replace_pkg::reg_addr_t'(`TS_ADDR_PID_BASE + `TS_PID_SLOTS), '0, "pid_oor");
		expect_reg(ts_replace_pkg::reg_addr_t'(`TS_ADDR_DATA_BASE + ts_replace_pkg::RAM_WORDS),
			'0, "data_oor");
		expect_reg(12'hfff, '0, "top_addr");
	endtask

	task automatic test_pass_through();
		send_packet(13'h0100, 2, 1'b1); // enabled pid but match off
		set_ctrl(1'b1, 1'b0);
		send_packet(13'h0200, 0, 1'b0); // disabled slot
		send_packet(13'h0333, 5, 1'b1);
		flush();
	endtask

	task automatic test_replace();
		send_packet(13'h0100, 0, 1'b0); // group 0
		send_packet(13'h1a5c, 0, 1'b0); // group 1
		send_packet(13'h0333, 3, 1'b0);
		send_packet(13'h0100, 1, 1'b1); // back to group 0
		flush();
	endtask

	task automatic test_bypass();
		set_ctrl(1'b1, 1'b1);
		send_packet(13'h0100, 2, 1'b1);
		flush();
		set_ctrl(1'b1, 1'b0);
		send_packet(13'h1a5c, 2, 1'b0); // rotation resumes at group 1
		flush();
	endtask

	initial begin
		exp_out_t z;
		void'($urandom(32'hda56));
		S_AXI_ARESETN = 1'b0;
		wr_strobe = 1'b0;
		wr = '0;
		rd_strobe = 1'b0;
		rd_addr = '0;
		ts_in_valid = 1'b0;
		ts_in = '0;
		in_valid_q = 1'b0;
		match_en_m = 1'b0;
		bypass_m = 1'b0;
		group_m = 0;
		for (int i = 0; i < `TS_PID_SLOTS; i++)
			pid_model[i] = '0;
		z = '0;
		repeat (3) exp_q.push_back(z); // delay line starts out zero
		repeat (3) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;
		test_reset_state();
		test_registers();
		test_pass_through();
		test_replace();
		test_bypass();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/ts_replace_top.sv
`timescale 1ns/1ns
`default_nettype none

module ts_replace_top (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      wr_strobe,
	input  ts_replace_pkg::reg_wr_t   wr,
	input  logic                      rd_strobe,
	input  ts_replace_pkg::reg_addr_t rd_addr,
	output logic                      rd_valid,
	output ts_replace_pkg::reg_data_t rd_data,
	input  logic                      ts_in_valid,
	input  ts_replace_pkg::ts_beat_t  ts_in,
	output logic                      ts_out_valid,
	output ts_replace_pkg::ts_beat_t  ts_out,
	output logic                      matched
);

	logic                       ram_we;
	ts_replace_pkg::ram_addr_t  ram_waddr;
	ts_replace_pkg::reg_data_t  ram_wdata;
	ts_replace_pkg::ram_addr_t  ram_raddr;
	ts_replace_pkg::reg_data_t  ram_rdata;
	logic                       match_enable;
	logic                       bypass;
	ts_replace_pkg::pid_table_t pid_table;
	ts_replace_pkg::byte_addr_t byte_addr;
	logic [7:0]                 byte_data;

	replace_regs u_regs (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.wr_strobe, .wr,
		.rd_strobe, .rd_addr, .rd_valid, .rd_data,
		.ram_we, .ram_waddr, .ram_wdata, .ram_raddr, .ram_rdata,
		.match_enable, .bypass, .pid_table
	);

	replace_packet_ram u_ram (
		.S_AXI_ACLK,
		.we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
		.raddr(ram_raddr), .rdata(ram_rdata),
		.byte_addr, .byte_data
	);

	ts_pid_replacer u_replacer (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.ts_in_valid, .ts_in,
		.match_enable, .bypass, .pid_table,
		.byte_addr, .byte_data,
		.ts_out_valid, .ts_out, .matched
	);

endmodule

`default_nettype wire

//--- hw/ts_pid_replacer.sv
`timescale 1ns/1ns
`default_nettype none
`include "ts_replace_config.svh"

module ts_pid_replacer (
	input  logic                       S_AXI_ACLK,
	input  logic                       S_AXI_ARESETN,
	input  logic                       ts_in_valid,
	input  ts_replace_pkg::ts_beat_t   ts_in,
	input  logic                       match_enable,
	input  logic                       bypass,
	input  ts_replace_pkg::pid_table_t pid_table,
	output ts_replace_pkg::byte_addr_t byte_addr,
	input  logic [7:0]                 byte_data,
	output logic                       ts_out_valid,
	output ts_replace_pkg::ts_beat_t   ts_out,
	output logic                       matched
);

	localparam int LAST_BYTE = `TS_PACKET_BYTES - 1;

	ts_replace_pkg::ts_beat_t [2:0] dly; // dly[0] newest

	ts_replace_pkg::replace_state_e state;
	ts_replace_pkg::byte_cnt_t      byte_cnt;
	ts_replace_pkg::group_idx_t     group_idx;
	ts_replace_pkg::group_idx_t     active_group;
	ts_replace_pkg::group_idx_t     group_next;

	logic [`TS_PID_WIDTH-1:0] rx_pid;
	logic [`TS_PID_SLOTS-1:0] slot_hit;
	logic                     head_seen;
	logic                     hit;
	logic                     replace_now;

	// ########################################
	// delay line
	// ########################################
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			dly <= '0;
		else if (ts_in_valid)
			dly <= {dly[1:0], ts_in};
	end

	// ########################################
	// sync and pid detection
	// ########################################
	// in: 2nd pid byte, dly[0]: 1st pid byte, dly[1]: sync byte
	assign rx_pid = {dly[0].data[4:0], ts_in.data};
	assign head_seen = ts_in_valid && dly[1].sync && (dly[1].data == `TS_SYNC_BYTE);

	always_comb begin
		for (int i = 0; i < `TS_PID_SLOTS; i++)
			slot_hit[i] = pid_table[i].enable && (pid_table[i].pid == rx_pid);
	end

	assign hit = head_seen && match_enable && !bypass && (|slot_hit);

	assign group_next = (group_idx == ts_replace_pkg::group_idx_t'(`TS_REPLACE_GROUPS - 1)) ?
		'0 : group_idx + 1'b1;

	// ########################################
	// replace FSM
	// ########################################
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state <= ts_replace_pkg::ST_PASS;
			byte_cnt <= '0;
			group_idx <= '0;
			active_group <= '0;
		end else if (ts_in_valid) begin
			if (state == ts_replace_pkg::ST_REPLACE) begin
				if (byte_cnt == ts_replace_pkg::byte_cnt_t'(LAST_BYTE)) begin
					state <= ts_replace_pkg::ST_PASS;
					byte_cnt <= '0;
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end
			// a new head can coincide with the last replaced byte
			if (hit) begin
				state <= ts_replace_pkg::ST_REPLACE;
				byte_cnt <= '0;
				active_group <= group_idx;
				group_idx <= group_next;
			end
		end
	end

	assign replace_now = (state == ts_replace_pkg::ST_REPLACE) && !bypass;
	assign byte_addr = ts_replace_pkg::byte_addr_t'(active_group * `TS_PACKET_BYTES + byte_cnt);

	// ########################################
	// output
	// ########################################
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			ts_out_valid <= 1'b0;
			matched <= 1'b0;
		end else begin
			ts_out_valid <= ts_in_valid;
			if (ts_in_valid)
				matched <= replace_now;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (ts_in_valid) begin
			ts_out.sync <= dly[2].sync; // sync kept from original
			ts_out.data <= replace_now ? byte_data : dly[2].data;
		end
	end

	a_out_follows_in: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		ts_out_valid |-> $past(ts_in_valid));
	a_byte_cnt_range: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		byte_cnt < `TS_PACKET_BYTES);

endmodule

`default_nettype wire

//--- hw/replace_packet_ram.sv
`timescale 1ns/1ns
`default_nettype none
`include "ts_replace_config.svh"

module replace_packet_ram (
	input  logic                       S_AXI_ACLK,
	input  logic                       we,
	input  ts_replace_pkg::ram_addr_t  waddr,
	input  ts_replace_pkg::reg_data_t  wdata,
	input  ts_replace_pkg::ram_addr_t  raddr,
	output ts_replace_pkg::reg_data_t  rdata,
	input  ts_replace_pkg::byte_addr_t byte_addr,
	output logic [7:0]                 byte_data
);

	localparam int LANE_W = $clog2(`TS_WORD_BYTES);

	ts_replace_pkg::reg_data_t mem [ts_replace_pkg::RAM_WORDS];

	ts_replace_pkg::ram_addr_t byte_word;
	logic [LANE_W-1:0]         byte_lane;
	ts_replace_pkg::reg_data_t byte_word_data;

	// ########################################
	// word port, registers side
	// ########################################
	always_ff @(posedge S_AXI_ACLK) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr]; // one cycle read
	end

	// ########################################
	// byte port, stream side
	// ########################################
	// group base is a multiple of 188 so byte/4 gives the word directly
	assign byte_word = ts_replace_pkg::ram_addr_t'(byte_addr / `TS_WORD_BYTES);
	assign byte_lane = LANE_W'(byte_addr % `TS_WORD_BYTES);

	assign byte_word_data = mem[byte_word];
	assign byte_data = byte_word_data[8*byte_lane +: 8]; // lane 0 in bits 7:0

	// regs decode must keep data writes inside the store
	a_waddr_range: assert property (@(posedge S_AXI_ACLK)
		we |-> (waddr < ts_replace_pkg::RAM_WORDS));

endmodule

`default_nettype wire

//--- hw/replace_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "ts_replace_config.svh"

module replace_regs (
	input  logic                       S_AXI_ACLK,
	input  logic                       S_AXI_ARESETN,
	input  logic                       wr_strobe,
	input  ts_replace_pkg::reg_wr_t    wr,
	input  logic                       rd_strobe,
	input  ts_replace_pkg::reg_addr_t  rd_addr,
	output logic                       rd_valid,
	output ts_replace_pkg::reg_data_t  rd_data,
	output logic                       ram_we,
	output ts_replace_pkg::ram_addr_t  ram_waddr,
	output ts_replace_pkg::reg_data_t  ram_wdata,
	output ts_replace_pkg::ram_addr_t  ram_raddr,
	input  ts_replace_pkg::reg_data_t  ram_rdata,
	output logic                       match_enable,
	output logic                       bypass,
	output ts_replace_pkg::pid_table_t pid_table
);

	ts_replace_pkg::reg_region_e wr_region;
	ts_replace_pkg::reg_region_e rd_region;
	ts_replace_pkg::pid_idx_t    wr_pid_idx;
	ts_replace_pkg::pid_idx_t    rd_pid_idx;
	ts_replace_pkg::reg_data_t   rd_word;
	ts_replace_pkg::reg_data_t   rd_word_q;
	logic                        rd_from_ram_q;

	function automatic ts_replace_pkg::reg_region_e decode(
		input ts_replace_pkg::reg_addr_t a
	);
		if (a == `TS_ADDR_CTRL)
			return ts_replace_pkg::REGION_CTRL;
		else if (a >= `TS_ADDR_PID_BASE && a < `TS_ADDR_PID_BASE + `TS_PID_SLOTS)
			return ts_replace_pkg::REGION_PID;
		else if (a >= `TS_ADDR_DATA_BASE &&
				a < `TS_ADDR_DATA_BASE + ts_replace_pkg::RAM_WORDS)
			return ts_replace_pkg::REGION_DATA;
		else
			return ts_replace_pkg::REGION_NONE;
	endfunction

	assign wr_region = decode(wr.addr);
	assign rd_region = decode(rd_addr);
	assign wr_pid_idx = ts_replace_pkg::pid_idx_t'(wr.addr - `TS_ADDR_PID_BASE);
	assign rd_pid_idx = ts_replace_pkg::pid_idx_t'(rd_addr - `TS_ADDR_PID_BASE);

	// ########################################
	// write side
	// ########################################
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			match_enable <= 1'b0;
			bypass <= 1'b0;
			pid_table <= '0;
		end else if (wr_strobe) begin
			case (wr_region)
				ts_replace_pkg::REGION_CTRL: begin
					match_enable <= wr.data[`TS_CTRL_MATCH_EN_BIT];
					bypass <= wr.data[`TS_CTRL_BYPASS_BIT];
				end
				ts_replace_pkg::REGION_PID: begin
					pid_table[wr_pid_idx].pid <= wr.data[`TS_PID_WIDTH-1:0];
					pid_table[wr_pid_idx].enable <= wr.data[`TS_PID_ENABLE_BIT];
				end
				default: ; // data goes straight to ram
			endcase
		end
	end

	assign ram_we = wr_strobe && (wr_region == ts_replace_pkg::REGION_DATA);
	assign ram_waddr = ts_replace_pkg::ram_addr_t'(wr.addr - `TS_ADDR_DATA_BASE);
	assign ram_wdata = wr.data;

	// ########################################
	// read side
	// ########################################
	assign ram_raddr = (rd_region == ts_replace_pkg::REGION_DATA) ?
		ts_replace_pkg::ram_addr_t'(rd_addr - `TS_ADDR_DATA_BASE) : '0;

	always_comb begin
		rd_word = '0;
		case (rd_region)
			ts_replace_pkg::REGION_CTRL: begin
				rd_word[`TS_CTRL_MATCH_EN_BIT] = match_enable;
				rd_word[`TS_CTRL_BYPASS_BIT] = bypass;
			end
			ts_replace_pkg::REGION_PID: begin
				rd_word[`TS_PID_WIDTH-1:0] = pid_table[rd_pid_idx].pid;
				rd_word[`TS_PID_ENABLE_BIT] = pid_table[rd_pid_idx].enable;
			end
			default: ;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			rd_valid <= 1'b0;
			rd_from_ram_q <= 1'b0;
		end else begin
			rd_valid <= rd_strobe;
			if (rd_strobe)
				rd_from_ram_q <= (rd_region == ts_replace_pkg::REGION_DATA);
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_strobe)
			rd_word_q <= rd_word;
	end

	// ram word lands together with rd_valid
	assign rd_data = rd_from_ram_q ? ram_rdata : rd_word_q;

	a_rd_latency: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		rd_strobe |=> rd_valid);

endmodule

`default_nettype wire

//--- hw/ts_replace_pkg.sv
`default_nettype none
`include "ts_replace_config.svh"

package ts_replace_pkg;

	localparam int RAM_WORDS = `TS_REPLACE_GROUPS * `TS_GROUP_WORDS;
	localparam int RAM_AW = $clog2(RAM_WORDS);
	localparam int BYTE_AW = $clog2(RAM_WORDS * `TS_WORD_BYTES);
	localparam int CNT_W = $clog2(`TS_PACKET_BYTES);
	localparam int GROUP_W = (`TS_REPLACE_GROUPS > 1) ? $clog2(`TS_REPLACE_GROUPS) : 1;
	localparam int SLOT_W = (`TS_PID_SLOTS > 1) ? $clog2(`TS_PID_SLOTS) : 1;

	typedef logic [`TS_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [`TS_DATA_WIDTH-1:0] reg_data_t;
	typedef logic [RAM_AW-1:0] ram_addr_t;
	typedef logic [BYTE_AW-1:0] byte_addr_t;
	typedef logic [CNT_W-1:0] byte_cnt_t;
	typedef logic [GROUP_W-1:0] group_idx_t;
	typedef logic [SLOT_W-1:0] pid_idx_t;

	// one stream byte, sync marks head of packet
	typedef struct packed {
		logic [7:0] data;
		logic       sync;
	} ts_beat_t;

	typedef struct packed {
		logic                     enable;
		logic [`TS_PID_WIDTH-1:0] pid;
	} pid_entry_t;

	typedef pid_entry_t [`TS_PID_SLOTS-1:0] pid_table_t;

	typedef struct packed {
		reg_addr_t addr;
		reg_data_t data;
	} reg_wr_t;

	typedef enum logic [1:0] {
		REGION_CTRL,
		REGION_PID,
		REGION_DATA,
		REGION_NONE
	} reg_region_e;

	typedef enum logic {ST_PASS, ST_REPLACE} replace_state_e;

endpackage

`default_nettype wire

//--- include/ts_replace_config.svh
`ifndef TS_REPLACE_CONFIG_SVH
`define TS_REPLACE_CONFIG_SVH

// ########################################
// transport stream sizes
// ########################################
`define TS_PACKET_BYTES 188
`define TS_WORD_BYTES 4
`define TS_GROUP_WORDS 47
`define TS_SYNC_BYTE 8'h47
`define TS_PID_WIDTH 13

// replacement store
`define TS_PID_SLOTS 4
`define TS_REPLACE_GROUPS 2

// ########################################
// register port and address map
// ########################################
`define TS_DATA_WIDTH 32
`define TS_ADDR_WIDTH 12
`define TS_ADDR_CTRL 12'h000
`define TS_ADDR_PID_BASE 12'h100
`define TS_ADDR_DATA_BASE 12'h400

// ctrl word and pid word bit positions
`define TS_CTRL_MATCH_EN_BIT 0
`define TS_CTRL_BYPASS_BIT 1
`define TS_PID_ENABLE_BIT 16

`endif
